/* src/ooo_pkg.sv */
package ooo_pkg;

    // Core sizes
    localparam int xlen      = 32;
    localparam int arch_regs = 32;
    localparam int phys_regs = 64;
    localparam int rob_depth = 16;

    typedef logic [xlen-1:0]               word_t;
    typedef logic [$clog2(arch_regs)-1:0]  arch_reg_t;
    typedef logic [$clog2(phys_regs)-1:0]  phys_tag_t;
    typedef logic [$clog2(rob_depth)-1:0]  rob_idx_t;

    // Micro-op opcodes, passed through to issue untouched
    typedef enum logic [3:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_sll,
        op_srl,
        op_load,
        op_store,
        op_branch
    } uop_op_e;

endpackage

/* src/rename_map.sv */
`timescale 1ns/1ps

module rename_map (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               in_valid,
    input  ooo_pkg::arch_reg_t in_src1,
    input  ooo_pkg::arch_reg_t in_src2,
    input  ooo_pkg::arch_reg_t in_dest,
    input  logic               rob_full,
    input  logic               commit_valid,
    input  ooo_pkg::phys_tag_t commit_old_tag,
    output logic               in_ready,
    output logic               in_fire,
    output ooo_pkg::phys_tag_t src1_tag,
    output ooo_pkg::phys_tag_t src2_tag,
    output ooo_pkg::phys_tag_t new_tag,
    output ooo_pkg::phys_tag_t old_tag,
    output logic               alloc_valid,
    output ooo_pkg::phys_tag_t alloc_tag
);
    import ooo_pkg::*;

    // Register alias table
    phys_tag_t rat [arch_regs];

    // Free list, circular over all physical tags
    phys_tag_t                   fl [phys_regs];
    phys_tag_t                   fl_head;
    phys_tag_t                   fl_tail;
    logic [$clog2(phys_regs):0]  fl_count;   // 0 to 64

    logic fl_pop;
    logic fl_push;

    assign in_ready = (fl_count != '0) && !rob_full;
    assign in_fire  = in_valid && in_ready;

    assign fl_pop  = in_fire;
    assign fl_push = commit_valid;   // Old tag is free once its overwriter commits

    // Sources see the mapping before this uop's own dest update
    assign src1_tag = rat[in_src1];
    assign src2_tag = rat[in_src2];
    assign old_tag  = rat[in_dest];
    assign new_tag  = fl[fl_head];

    assign alloc_valid = in_fire;
    assign alloc_tag   = new_tag;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < arch_regs; i++) begin
                rat[i] <= phys_tag_t'(i);   // Identity map
            end
        end else if (in_fire) begin
            rat[in_dest] <= new_tag;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            // Tags above the architectural ones start out free, ascending
            for (int i = 0; i < phys_regs; i++) begin
                if (i < phys_regs - arch_regs) begin
                    fl[i] <= phys_tag_t'(i + arch_regs);
                end else begin
                    fl[i] <= '0;
                end
            end
            fl_head  <= '0;
            fl_tail  <= phys_tag_t'(phys_regs - arch_regs);
            fl_count <= ($clog2(phys_regs)+1)'(phys_regs - arch_regs);
        end else begin
            if (fl_push) begin
                fl[fl_tail] <= commit_old_tag;
                fl_tail     <= fl_tail + 1'b1;   // Wraps at 64
            end
            if (fl_pop) begin
                fl_head <= fl_head + 1'b1;
            end
            case ({fl_push, fl_pop})
                2'b10:   fl_count <= fl_count + 1'b1;
                2'b01:   fl_count <= fl_count - 1'b1;
                default: fl_count <= fl_count;
            endcase
        end
    end

    // Commits can never return more tags than exist
    a_fl_no_overflow: assert property (
        @(posedge clk) disable iff (!arst_n)
        fl_push |-> fl_count != ($clog2(phys_regs)+1)'(phys_regs)
    );

endmodule

/* src/phys_regfile.sv */
`timescale 1ns/1ps

module phys_regfile (
    input  logic               clk,
    input  logic               arst_n,
    input  ooo_pkg::phys_tag_t src1_tag,
    input  ooo_pkg::phys_tag_t src2_tag,
    input  logic               alloc_valid,
    input  ooo_pkg::phys_tag_t alloc_tag,
    input  logic               wb_valid,
    input  ooo_pkg::phys_tag_t wb_tag,
    input  ooo_pkg::word_t     wb_value,
    output logic               src1_rdy,
    output logic               src2_rdy,
    output ooo_pkg::word_t     src1_val,
    output ooo_pkg::word_t     src2_val
);
    import ooo_pkg::*;

    word_t                regs [phys_regs];
    logic [phys_regs-1:0] rdy;

    logic src1_hit;
    logic src2_hit;

    // Same-cycle writeback forwarding
    assign src1_hit = wb_valid && (wb_tag == src1_tag);
    assign src2_hit = wb_valid && (wb_tag == src2_tag);

    assign src1_rdy = src1_hit ? 1'b1 : rdy[src1_tag];
    assign src2_rdy = src2_hit ? 1'b1 : rdy[src2_tag];
    assign src1_val = src1_hit ? wb_value : regs[src1_tag];
    assign src2_val = src2_hit ? wb_value : regs[src2_tag];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < phys_regs; i++) begin
                rdy[i] <= (i < arch_regs);   // Only the identity-mapped tags hold state
            end
        end else begin
            if (alloc_valid) begin
                rdy[alloc_tag] <= 1'b0;
            end
            if (wb_valid) begin
                rdy[wb_tag] <= 1'b1;
            end
        end
    end

    // Architectural state reads as zero out of reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < phys_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_valid) begin
            regs[wb_tag] <= wb_value;
        end
    end

    // A tag still in the free list can't be producing a result
    a_alloc_wb_disjoint: assert property (
        @(posedge clk) disable iff (!arst_n)
        (alloc_valid && wb_valid) |-> alloc_tag != wb_tag
    );

endmodule

/* src/dispatch.sv */
`timescale 1ns/1ps

module dispatch (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               in_fire,
    input  ooo_pkg::uop_op_e   in_op,
    input  logic               in_eoi,
    input  ooo_pkg::word_t     in_imm,
    input  logic               in_use_imm,
    input  ooo_pkg::word_t     in_pc,
    input  logic               src1_rdy,
    input  logic               src2_rdy,
    input  ooo_pkg::phys_tag_t src1_tag,
    input  ooo_pkg::phys_tag_t src2_tag,
    input  ooo_pkg::word_t     src1_val,
    input  ooo_pkg::word_t     src2_val,
    input  ooo_pkg::phys_tag_t new_tag,
    input  ooo_pkg::rob_idx_t  rob_tail,
    output logic               out_valid,
    output ooo_pkg::uop_op_e   out_op,
    output logic               out_eoi,
    output logic               op1_rdy,
    output ooo_pkg::phys_tag_t op1_tag,
    output ooo_pkg::word_t     op1_val,
    output logic               op2_rdy,
    output ooo_pkg::phys_tag_t op2_tag,
    output ooo_pkg::word_t     op2_val,
    output ooo_pkg::phys_tag_t out_dest_tag,
    output ooo_pkg::word_t     out_pc,
    output ooo_pkg::rob_idx_t  out_rob_entry
);
    import ooo_pkg::*;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_fire;   // One-cycle pulse per accepted uop
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            out_op        <= in_op;
            out_eoi       <= in_eoi;
            op1_rdy       <= src1_rdy;
            op1_tag       <= src1_tag;
            op1_val       <= src1_val;
            // Immediate operand is always ready
            op2_rdy       <= in_use_imm ? 1'b1 : src2_rdy;
            op2_tag       <= in_use_imm ? phys_tag_t'(0) : src2_tag;
            op2_val       <= in_use_imm ? in_imm : src2_val;
            out_dest_tag  <= new_tag;
            out_pc        <= in_pc;
            out_rob_entry <= rob_tail;   // Slot being filled this edge
        end
    end

endmodule

/* src/reorder_buffer.sv */
`timescale 1ns/1ps

module reorder_buffer (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               in_fire,
    input  ooo_pkg::arch_reg_t in_dest,
    input  ooo_pkg::phys_tag_t new_tag,
    input  ooo_pkg::phys_tag_t old_tag,
    input  logic               in_except,
    input  logic               wb_valid,
    input  ooo_pkg::rob_idx_t  wb_rob_entry,
    output ooo_pkg::rob_idx_t  rob_tail,
    output logic               rob_full,
    output logic               commit_valid,
    output ooo_pkg::arch_reg_t commit_dest_arch,
    output ooo_pkg::phys_tag_t commit_dest_tag,
    output ooo_pkg::phys_tag_t commit_old_tag,
    output logic               commit_except
);
    import ooo_pkg::*;

    logic [rob_depth-1:0] valid;
    logic [rob_depth-1:0] done;

    // Payload captured at rename
    arch_reg_t ent_dest [rob_depth];
    phys_tag_t ent_new  [rob_depth];
    phys_tag_t ent_old  [rob_depth];
    logic      ent_exc  [rob_depth];

    rob_idx_t                    head;
    rob_idx_t                    tail;
    logic [$clog2(rob_depth):0]  count;

    assign rob_tail = tail;
    assign rob_full = (count == ($clog2(rob_depth)+1)'(rob_depth));

    // Head retires once its result is back
    assign commit_valid     = valid[head] && done[head];
    assign commit_dest_arch = ent_dest[head];
    assign commit_dest_tag  = ent_new[head];
    assign commit_old_tag   = ent_old[head];
    assign commit_except    = ent_exc[head];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid <= '0;
            done  <= '0;
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (wb_valid) begin
                done[wb_rob_entry] <= 1'b1;
            end
            if (commit_valid) begin
                valid[head] <= 1'b0;
                head        <= head + 1'b1;
            end
            if (in_fire) begin
                valid[tail] <= 1'b1;
                done[tail]  <= 1'b0;
                tail        <= tail + 1'b1;
            end
            case ({in_fire, commit_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            ent_dest[tail] <= in_dest;
            ent_new[tail]  <= new_tag;
            ent_old[tail]  <= old_tag;
            ent_exc[tail]  <= in_except;
        end
    end

    // One writeback per in-flight uop
    a_wb_live_entry: assert property (
        @(posedge clk) disable iff (!arst_n)
        wb_valid |-> (valid[wb_rob_entry] && !done[wb_rob_entry])
    );

endmodule

/* src/rename_dispatch.sv */
`timescale 1ns/1ps

module rename_dispatch (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               in_valid,
    output logic               in_ready,
    input  ooo_pkg::uop_op_e   in_op,
    input  logic               in_eoi,
    input  ooo_pkg::arch_reg_t in_src1,
    input  ooo_pkg::arch_reg_t in_src2,
    input  ooo_pkg::arch_reg_t in_dest,
    input  ooo_pkg::word_t     in_imm,
    input  logic               in_use_imm,
    input  ooo_pkg::word_t     in_pc,
    input  logic               in_except,
    input  logic               wb_valid,
    input  ooo_pkg::phys_tag_t wb_tag,
    input  ooo_pkg::word_t     wb_value,
    input  ooo_pkg::rob_idx_t  wb_rob_entry,
    output logic               out_valid,
    output ooo_pkg::uop_op_e   out_op,
    output logic               out_eoi,
    output logic               op1_rdy,
    output ooo_pkg::phys_tag_t op1_tag,
    output ooo_pkg::word_t     op1_val,
    output logic               op2_rdy,
    output ooo_pkg::phys_tag_t op2_tag,
    output ooo_pkg::word_t     op2_val,
    output ooo_pkg::phys_tag_t out_dest_tag,
    output ooo_pkg::word_t     out_pc,
    output ooo_pkg::rob_idx_t  out_rob_entry,
    output logic               commit_valid,
    output ooo_pkg::arch_reg_t commit_dest_arch,
    output ooo_pkg::phys_tag_t commit_dest_tag,
    output ooo_pkg::phys_tag_t commit_old_tag,
    output logic               commit_except
);
    import ooo_pkg::*;

    logic      in_fire;
    logic      rob_full;
    logic      alloc_valid;
    phys_tag_t alloc_tag;
    phys_tag_t src1_tag;
    phys_tag_t src2_tag;
    phys_tag_t new_tag;
    phys_tag_t old_tag;
    logic      src1_rdy;
    logic      src2_rdy;
    word_t     src1_val;
    word_t     src2_val;
    rob_idx_t  rob_tail;

    rename_map u_rename_map (
        .clk            (clk),
        .arst_n         (arst_n),
        .in_valid       (in_valid),
        .in_src1        (in_src1),
        .in_src2        (in_src2),
        .in_dest        (in_dest),
        .rob_full       (rob_full),
        .commit_valid   (commit_valid),
        .commit_old_tag (commit_old_tag),
        .in_ready       (in_ready),
        .in_fire        (in_fire),
        .src1_tag       (src1_tag),
        .src2_tag       (src2_tag),
        .new_tag        (new_tag),
        .old_tag        (old_tag),
        .alloc_valid    (alloc_valid),
        .alloc_tag      (alloc_tag)
    );

    phys_regfile u_phys_regfile (
        .clk         (clk),
        .arst_n      (arst_n),
        .src1_tag    (src1_tag),
        .src2_tag    (src2_tag),
        .alloc_valid (alloc_valid),
        .alloc_tag   (alloc_tag),
        .wb_valid    (wb_valid),
        .wb_tag      (wb_tag),
        .wb_value    (wb_value),
        .src1_rdy    (src1_rdy),
        .src2_rdy    (src2_rdy),
        .src1_val    (src1_val),
        .src2_val    (src2_val)
    );

    dispatch u_dispatch (
        .clk           (clk),
        .arst_n        (arst_n),
        .in_fire       (in_fire),
        .in_op         (in_op),
        .in_eoi        (in_eoi),
        .in_imm        (in_imm),
        .in_use_imm    (in_use_imm),
        .in_pc         (in_pc),
        .src1_rdy      (src1_rdy),
        .src2_rdy      (src2_rdy),
        .src1_tag      (src1_tag),
        .src2_tag      (src2_tag),
        .src1_val      (src1_val),
        .src2_val      (src2_val),
        .new_tag       (new_tag),
        .rob_tail      (rob_tail),
        .out_valid     (out_valid),
        .out_op        (out_op),
        .out_eoi       (out_eoi),
        .op1_rdy       (op1_rdy),
        .op1_tag       (op1_tag),
        .op1_val       (op1_val),
        .op2_rdy       (op2_rdy),
        .op2_tag       (op2_tag),
        .op2_val       (op2_val),
        .out_dest_tag  (out_dest_tag),
        .out_pc        (out_pc),
        .out_rob_entry (out_rob_entry)
    );

    reorder_buffer u_reorder_buffer (
        .clk              (clk),
        .arst_n           (arst_n),
        .in_fire          (in_fire),
        .in_dest          (in_dest),
        .new_tag          (new_tag),
        .old_tag          (old_tag),
        .in_except        (in_except),
        .wb_valid         (wb_valid),
        .wb_rob_entry     (wb_rob_entry),
        .rob_tail         (rob_tail),
        .rob_full         (rob_full),
        .commit_valid     (commit_valid),
        .commit_dest_arch (commit_dest_arch),
        .commit_dest_tag  (commit_dest_tag),
        .commit_old_tag   (commit_old_tag),
        .commit_except    (commit_except)
    );

endmodule

/* verification/rename_dispatch_tb.sv */
`timescale 1ns/1ps

module rename_dispatch_tb;
    import ooo_pkg::*;

    typedef enum logic [1:0] {wb_now, wb_later, wb_never} wb_mode_e;

    typedef struct packed {
        uop_op_e   op;
        arch_reg_t src1;
        arch_reg_t src2;
        arch_reg_t dest;
        word_t     imm;
        logic      use_imm;
        logic      except;
        word_t     wb_val;
        wb_mode_e  mode;
    } row_t;

    // What the ROB should hand back at commit
    typedef struct packed {
        arch_reg_t dest;
        phys_tag_t new_tag;
        phys_tag_t old_tag;
        logic      except;
        rob_idx_t  entry;
    } commit_t;

    logic      clk, arst_n, in_valid, in_ready, in_eoi, in_use_imm, in_except, wb_valid;
    uop_op_e   in_op, out_op;
    arch_reg_t in_src1, in_src2, in_dest, commit_dest_arch;
    word_t     in_imm, in_pc, wb_value, op1_val, op2_val, out_pc;
    phys_tag_t wb_tag, op1_tag, op2_tag, out_dest_tag, commit_dest_tag, commit_old_tag;
    rob_idx_t  wb_rob_entry, out_rob_entry;
    logic      out_valid, out_eoi, op1_rdy, op2_rdy, commit_valid, commit_except;

    // Reference model state
    row_t      rows [$];
    string     names [$];
    phys_tag_t rat_m [arch_regs];
    logic      rdy_m [phys_regs];
    word_t     val_m [phys_regs];
    logic      wb_seen [rob_depth];
    phys_tag_t free_m [$];
    commit_t   pend_commits [$];
    commit_t   held [$];
    commit_t   exp_c;
    rob_idx_t  tail_m;
    int        errors, test_errs, tests, failed, seq, cycles, cycle_limit;

    rename_dispatch dut0 (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timed out after %0d cycles waiting on the DUT", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic check_tag(string name, phys_tag_t exp, phys_tag_t act);
        if (exp !== act) begin
            $display("FAIL %s: expected %0d, got %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_word(string name, word_t exp, word_t act);
        if (exp !== act) begin
            $display("FAIL %s: expected %h, got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (exp !== act) begin
            $display("FAIL %s: expected %b, got %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_op(string name, uop_op_e exp, uop_op_e act);
        if (exp !== act) begin
            $display("FAIL %s: expected %s, got %s", name, exp.name(), act.name());
            errors++;
        end
    endtask

    task automatic check_reg(string name, arch_reg_t exp, arch_reg_t act);
        if (exp !== act) begin
            $display("FAIL %s: expected r%0d, got r%0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_idx(string name, rob_idx_t exp, rob_idx_t act);
        if (exp !== act) begin
            $display("FAIL %s: expected %0d, got %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic report_test(string name);
        if (errors == test_errs) begin
            $display("test %-16s ok", name);
        end else begin
            $display("test %-16s %0d mismatches", name, errors - test_errs);
            failed++;
        end
        test_errs = errors;
        tests++;
    endtask

    task automatic add_row(string name, uop_op_e op, arch_reg_t s1, arch_reg_t s2,
                           arch_reg_t d, word_t imm, logic use_imm, logic exc,
                           word_t wbv, wb_mode_e mode);
        rows.push_back('{op, s1, s2, d, imm, use_imm, exc, wbv, mode});
        names.push_back(name);
    endtask

    task automatic drive_uop(row_t r);
        in_valid   = 1'b1;
        in_op      = r.op;
        in_src1    = r.src1;
        in_src2    = r.src2;
        in_dest    = r.dest;
        in_imm     = r.imm;
        in_use_imm = r.use_imm;
        in_except  = r.except;
        in_eoi     = seq[0];
        in_pc      = 32'h0000_1000 + word_t'(seq) * 4;
    endtask

    // Model sees the value now, which matches what the bypass shows this cycle
    task automatic drive_wb(phys_tag_t tag, rob_idx_t entry, word_t value);
        wb_valid     = 1'b1;
        wb_tag       = tag;
        wb_rob_entry = entry;
        wb_value     = value;
        rdy_m[tag]   = 1'b1;
        val_m[tag]   = value;
        wb_seen[entry] = 1'b1;
    endtask

    task automatic finish_uop(string name, row_t r, output commit_t c);
        phys_tag_t t1, t2;
        logic      r1, r2;
        word_t     v1, v2;
        while (!in_ready) begin
            @(posedge clk);
            #1;
            wb_valid = 1'b0;   // Writeback lasts one cycle only
        end
        t1 = rat_m[r.src1];
        r1 = rdy_m[t1];
        v1 = val_m[t1];
        t2 = r.use_imm ? phys_tag_t'(0) : rat_m[r.src2];
        r2 = r.use_imm ? 1'b1 : rdy_m[t2];
        v2 = r.use_imm ? r.imm : val_m[t2];
        c = '{r.dest, free_m.pop_front(), rat_m[r.dest], r.except, tail_m};
        rat_m[r.dest]    = c.new_tag;
        rdy_m[c.new_tag] = 1'b0;
        wb_seen[tail_m]  = 1'b0;
        pend_commits.push_back(c);
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        wb_valid = 1'b0;
        check_bit({name, " out_valid"}, 1'b1, out_valid);
        check_op({name, " op"}, r.op, out_op);
        check_bit({name, " eoi"}, seq[0], out_eoi);
        check_word({name, " pc"}, 32'h0000_1000 + word_t'(seq) * 4, out_pc);
        check_tag({name, " op1 tag"}, t1, op1_tag);
        check_bit({name, " op1 rdy"}, r1, op1_rdy);
        if (r1) check_word({name, " op1 val"}, v1, op1_val);
        check_tag({name, " op2 tag"}, t2, op2_tag);
        check_bit({name, " op2 rdy"}, r2, op2_rdy);
        if (r2) check_word({name, " op2 val"}, v2, op2_val);
        check_tag({name, " dest tag"}, c.new_tag, out_dest_tag);
        check_idx({name, " rob entry"}, c.entry, out_rob_entry);
        tail_m++;
        seq++;
    endtask

    // Commits must follow program order and return the old tag
    always @(negedge clk) begin
        if (arst_n && commit_valid) begin
            if (pend_commits.size() == 0) begin
                $display("Commit seen with no micro-op outstanding");
                errors++;
            end else begin
                exp_c = pend_commits.pop_front();
                if (!wb_seen[exp_c.entry]) begin
                    $display("ROB entry %0d committed before its writeback", exp_c.entry);
                    errors++;
                end
                check_reg("commit dest", exp_c.dest, commit_dest_arch);
                check_tag("commit new tag", exp_c.new_tag, commit_dest_tag);
                check_tag("commit old tag", exp_c.old_tag, commit_old_tag);
                check_bit("commit except", exp_c.except, commit_except);
                free_m.push_back(exp_c.old_tag);
            end
        end
    end

    initial begin
        commit_t c;
        commit_t head;
        commit_t now_wb;
        word_t   now_val;
        logic    have_wb;
        void'($urandom(32'h3d59));
        {clk, arst_n, in_valid, in_eoi, in_use_imm, in_except, wb_valid} = '0;
        in_op = op_add;
        {in_src1, in_src2, in_dest, in_imm, in_pc} = '0;
        {wb_tag, wb_value, wb_rob_entry} = '0;
        for (int i = 0; i < phys_regs; i++) begin
            rdy_m[i] = (i < arch_regs);
            val_m[i] = '0;
            if (i < arch_regs) rat_m[i] = phys_tag_t'(i);
            else free_m.push_back(phys_tag_t'(i));
        end
        for (int i = 0; i < rob_depth; i++) wb_seen[i] = 1'b0;
        tail_m = '0;

        //       name             op         s1  s2  d   imm            ui exc wb value     mode
        add_row("init_map",       op_add,    1,  2,  3,  32'h0,         0, 0, 32'h0000_0011, wb_now);
        add_row("bypass_read",    op_sub,    3,  4,  5,  32'h0,         0, 0, 32'h0000_0022, wb_later);
        add_row("alloc_pending",  op_and,    5,  6,  7,  32'h0,         0, 0, 32'h0000_0033, wb_later);
        add_row("wb_ready",       op_or,     3,  0,  8,  32'h0,         0, 0, 32'h0000_0044, wb_later);
        add_row("imm_operand",    op_load,   2,  9,  9,  32'h0000_0f40, 1, 0, 32'h0000_0055, wb_later);
        add_row("imm_pending",    op_xor,    7,  1,  10, 32'hffff_fff0, 1, 1, 32'h0000_0066, wb_later);
        add_row("store_pass",     op_store,  9,  8,  11, 32'h0,         0, 0, 32'h0000_0077, wb_later);
        add_row("overwrite_dest", op_sll,    3,  3,  3,  32'h0,         0, 0, 32'h0000_0088, wb_now);
        add_row("bypass_again",   op_srl,    3,  7,  12, 32'h0,         0, 0, 32'h0000_0099, wb_later);
        add_row("branch_except",  op_branch, 12, 0,  13, 32'h0000_0010, 0, 1, 32'h0000_00aa, wb_later);
        cycle_limit = 20 * rows.size() + 200;

        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;
        check_bit("reset in_ready", 1'b1, in_ready);
        check_bit("reset out_valid", 1'b0, out_valid);
        check_bit("reset commit_valid", 1'b0, commit_valid);
        report_test("reset_state");

        // Second pass renames over the mappings the first one left behind
        repeat (2) begin
            have_wb = 1'b0;
            for (int i = 0; i < rows.size(); i++) begin
                drive_uop(rows[i]);
                if (have_wb) drive_wb(now_wb.new_tag, now_wb.entry, now_val);
                have_wb = 1'b0;
                finish_uop(names[i], rows[i], c);
                if (rows[i].mode == wb_now) begin
                    have_wb = 1'b1;
                    now_wb  = c;
                    now_val = rows[i].wb_val;
                end else if (rows[i].mode == wb_later) begin
                    held.push_back(c);
                end
                report_test(names[i]);
            end
            if (have_wb) begin
                drive_wb(now_wb.new_tag, now_wb.entry, now_val);
                @(posedge clk);
                #1;
                wb_valid = 1'b0;
            end
            // Youngest first
            while (held.size() != 0) begin
                c = held.pop_back();
                drive_wb(c.new_tag, c.entry, $urandom);
                @(posedge clk);
                #1;
                wb_valid = 1'b0;
            end
            while (pend_commits.size() != 0) begin
                @(posedge clk);
                #1;
            end
            report_test("commit_order");
        end

        // Free list wraps into recycled tags here
        for (int k = 0; k < rob_depth; k++) begin
            drive_uop(rows[k % rows.size()]);
            finish_uop("back_pressure", rows[k % rows.size()], c);
            if (k == 0) head = c;
        end
        check_bit("rob full in_ready", 1'b0, in_ready);
        drive_uop(rows[0]);
        repeat (3) begin
            @(posedge clk);
            #1;
            check_bit("stalled in_ready", 1'b0, in_ready);
            check_bit("stalled out_valid", 1'b0, out_valid);
        end
        drive_wb(head.new_tag, head.entry, $urandom);
        finish_uop("reopen", rows[0], c);
        report_test("back_pressure");

        $display("%0d tests, %0d failed, %0d check errors", tests, failed, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* rename_dispatch.f */
src/ooo_pkg.sv
src/rename_map.sv
src/phys_regfile.sv
src/dispatch.sv
src/reorder_buffer.sv
src/rename_dispatch.sv
verification/rename_dispatch_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = rename_dispatch_tb
FILELIST  = rename_dispatch.f
OBJ_DIR   = obj_dir
PASS_MSG  = Verification passed

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
